/* all.f */
hw/rtf_pkg.sv
hw/rtf_ctrl.sv
hw/rtf_sweep_counter.sv
hw/gram_accumulator.sv
hw/gram_inverse.sv
hw/rtf_projector.sv
hw/rtf_top.sv
testbench/rtf_tb_properties.sv
testbench/rtf_tb.sv

/* hw/gram_accumulator.sv */
module gram_accumulator #(
    parameter int MIC_NUM = 8
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         acc_clear,
    input  logic                         acc_en,
    input  logic [$clog2(2*MIC_NUM)-1:0] idx,
    input  logic                         src_sel,
    input  rtf_pkg::cplx_t               rd_data,
    output rtf_pkg::gram_t               gram,
    output rtf_pkg::cplx_t               a0_m,
    output rtf_pkg::cplx_t               a1_m
);
    import rtf_pkg::*;

    localparam int IDX_W = $clog2(2*MIC_NUM);
    localparam int MIC_W = $clog2(MIC_NUM);

    cplx_t                    buf0 [MIC_NUM];
    cplx_t                    buf1 [MIC_NUM];
    logic [MIC_W-1:0]         mic;
    logic signed [DATA_W-1:0] s_re, s_im;   // incoming sample
    logic signed [DATA_W-1:0] p_re, p_im;   // source 0 sample, same mic
    logic signed [ACC_W-1:0]  mag_sq, x_re, x_im;

    assign mic  = MIC_W'(src_sel ? idx - IDX_W'(MIC_NUM) : idx);
    assign s_re = rd_data.re;
    assign s_im = rd_data.im;
    assign p_re = buf0[mic].re;
    assign p_im = buf0[mic].im;

    assign mag_sq = s_re * s_re + s_im * s_im;
    assign x_re   = p_re * s_re + p_im * s_im;   // conj(a0) * a1
    assign x_im   = p_re * s_im - p_im * s_re;

    always_ff @(posedge clk) begin
        if (acc_en) begin
            if (src_sel)
                buf1[mic] <= rd_data;
            else
                buf0[mic] <= rd_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gram <= '0;
        end else if (acc_clear) begin
            gram <= '0;
        end else if (acc_en) begin
            if (src_sel) begin
                gram.g22    <= gram.g22 + mag_sq;
                gram.g12_re <= gram.g12_re + x_re;
                gram.g12_im <= gram.g12_im + x_im;
            end else begin
                gram.g11    <= gram.g11 + mag_sq;
            end
        end
    end

    assign a0_m = buf0[mic];
    assign a1_m = buf1[mic];

endmodule

/* hw/gram_inverse.sv */
module gram_inverse #(
    parameter int LAMBDA = 2684355
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        inv_load,
    input  logic                        inv_scale,
    input  rtf_pkg::gram_t              gram,
    input  logic [rtf_pkg::RECIP_W-1:0] div_recip,
    output logic [rtf_pkg::WIDE_W-1:0]  div_det,
    output rtf_pkg::inv_t               inv
);
    import rtf_pkg::*;

    logic                     ld_d1, ld_d2;
    logic signed [ACC_W-1:0]  g11_l, g22_l, g12_re_l, g12_im_l;
    logic signed [WIDE_W-1:0] g11_w, g22_w, re_w, im_w, recip_w;
    logic signed [WIDE_W-1:0] diag_prod, off_sq, det;

    // sign extension to the wide datapath
    assign g11_w   = g11_l;
    assign g22_w   = g22_l;
    assign re_w    = g12_re_l;
    assign im_w    = g12_im_l;
    assign recip_w = $signed(div_recip);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ld_d1 <= 1'b0;
            ld_d2 <= 1'b0;
        end else begin
            ld_d1 <= inv_load;
            ld_d2 <= ld_d1;
        end
    end

    // ==================================================
    // diagonal loading and determinant
    // ==================================================
    always_ff @(posedge clk) begin
        if (inv_load) begin
            g11_l    <= gram.g11 + ACC_W'(LAMBDA);
            g22_l    <= gram.g22 + ACC_W'(LAMBDA);
            g12_re_l <= gram.g12_re;
            g12_im_l <= gram.g12_im;
        end
        if (ld_d1) begin
            diag_prod <= g11_w * g22_w;
            off_sq    <= re_w * re_w + im_w * im_w;   // |g12|^2 in its own stage
        end
        if (ld_d2)
            det <= diag_prod - off_sq;
    end

    assign div_det = det;

    // ==================================================
    // adjugate times reciprocal
    // ==================================================
    always_ff @(posedge clk) begin
        if (inv_scale) begin
            inv.i11    <= g22_w * recip_w;
            inv.i22    <= g11_w * recip_w;
            inv.i12_re <= -(re_w * recip_w);
            inv.i12_im <= -(im_w * recip_w);
        end
    end

endmodule

/* hw/rtf_ctrl.sv */
module rtf_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic div_ack,
    input  logic last,
    input  logic timer_done,
    output logic done,
    output logic div_req,
    output logic acc_clear,
    output logic acc_en,
    output logic inv_load,
    output logic inv_scale,
    output logic proj_en,
    output logic wr_en,
    output logic cnt_clear,
    output logic cnt_step,
    output logic timer_start
);
    import rtf_pkg::*;

    ctrl_state_t state, state_nxt;
    logic        det_ph;   // second determinant cycle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= ST_IDLE;
            det_ph <= 1'b0;
        end else begin
            state  <= state_nxt;
            det_ph <= (state == ST_DET) ? ~det_ph : 1'b0;
        end
    end

    // ==================================================
    // next state and step strobes
    // ==================================================
    always_comb begin
        state_nxt   = state;
        acc_clear   = 1'b0;
        acc_en      = 1'b0;
        inv_load    = 1'b0;
        inv_scale   = 1'b0;
        proj_en     = 1'b0;
        cnt_clear   = 1'b0;
        cnt_step    = 1'b0;
        timer_start = 1'b0;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    acc_clear = 1'b1;
                    cnt_clear = 1'b1;
                    state_nxt = ST_READ;
                end
            end
            ST_READ: begin   // address out, start latency wait
                timer_start = 1'b1;
                state_nxt   = ST_WAIT;
            end
            ST_WAIT: begin
                if (timer_done) begin
                    acc_en    = 1'b1;   // sample valid this cycle
                    cnt_step  = 1'b1;
                    state_nxt = last ? ST_LOAD : ST_READ;
                end
            end
            ST_LOAD: begin
                inv_load  = 1'b1;
                state_nxt = ST_DET;
            end
            ST_DET:     state_nxt = det_ph ? ST_DIV_REQ : ST_DET;
            ST_DIV_REQ: begin
                if (div_ack) begin
                    inv_scale = 1'b1;   // recip only valid while ack is high
                    state_nxt = ST_DIV_REL;
                end
            end
            ST_DIV_REL: state_nxt = div_ack ? ST_DIV_REL : ST_SCALE;
            ST_SCALE: begin
                cnt_clear = 1'b1;
                state_nxt = ST_PROJ;
            end
            ST_PROJ: begin
                proj_en   = 1'b1;
                state_nxt = ST_WRITE;
            end
            ST_WRITE: begin
                cnt_step  = 1'b1;
                state_nxt = last ? ST_DONE : ST_PROJ;
            end
            ST_DONE:    state_nxt = start ? ST_DONE : ST_IDLE;
            default:    state_nxt = ST_IDLE;
        endcase
    end

    assign done    = (state == ST_DONE);
    assign div_req = (state == ST_DIV_REQ);
    assign wr_en   = (state == ST_WRITE);

endmodule

/* hw/rtf_pkg.sv */
package rtf_pkg;

    localparam int DATA_W  = 16;
    localparam int ACC_W   = 40;
    localparam int WIDE_W  = 64;
    localparam int RECIP_W = 32;

    typedef struct packed {
        logic signed [DATA_W-1:0] re;
        logic signed [DATA_W-1:0] im;
    } cplx_t;

    // hermitian gram, g21 = conj(g12) so it is not stored
    typedef struct packed {
        logic signed [ACC_W-1:0] g11;
        logic signed [ACC_W-1:0] g22;
        logic signed [ACC_W-1:0] g12_re;
        logic signed [ACC_W-1:0] g12_im;
    } gram_t;

    typedef struct packed {
        logic signed [WIDE_W-1:0] i11;
        logic signed [WIDE_W-1:0] i22;
        logic signed [WIDE_W-1:0] i12_re;
        logic signed [WIDE_W-1:0] i12_im;
    } inv_t;

    typedef struct packed {
        logic signed [WIDE_W-1:0] re;
        logic signed [WIDE_W-1:0] im;
    } wide_cplx_t;

    typedef enum logic [3:0] {
        ST_IDLE, ST_READ, ST_WAIT, ST_LOAD, ST_DET, ST_DIV_REQ,
        ST_DIV_REL, ST_SCALE, ST_PROJ, ST_WRITE, ST_DONE
    } ctrl_state_t;

endpackage

/* hw/rtf_projector.sv */
module rtf_projector (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                proj_en,
    input  logic                src_sel,
    input  rtf_pkg::inv_t       inv,
    input  rtf_pkg::cplx_t      a0_m,
    input  rtf_pkg::cplx_t      a1_m,
    output rtf_pkg::wide_cplx_t wr_data
);
    import rtf_pkg::*;

    // c * conj(a), wraps at WIDE_W
    function automatic wide_cplx_t mul_conj(
        input logic signed [WIDE_W-1:0] c_re,
        input logic signed [WIDE_W-1:0] c_im,
        input cplx_t                    a
    );
        logic signed [WIDE_W-1:0] a_re;
        logic signed [WIDE_W-1:0] a_im;
        wide_cplx_t               r;
        a_re = $signed(a.re);
        a_im = $signed(a.im);
        r.re = c_re * a_re + c_im * a_im;
        r.im = c_im * a_re - c_re * a_im;
        return r;
    endfunction

    logic signed [WIDE_W-1:0] cx_re, cx_im;   // weight on source 0
    logic signed [WIDE_W-1:0] cy_re, cy_im;   // weight on source 1
    wide_cplx_t               px, py;

    always_comb begin
        if (src_sel) begin   // row 1: conj(i12), i22
            cx_re = inv.i12_re;
            cx_im = -inv.i12_im;
            cy_re = inv.i22;
            cy_im = '0;
        end else begin       // row 0: i11, i12
            cx_re = inv.i11;
            cx_im = '0;
            cy_re = inv.i12_re;
            cy_im = inv.i12_im;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            px <= '0;
            py <= '0;
        end else if (proj_en) begin
            px <= mul_conj(cx_re, cx_im, a0_m);
            py <= mul_conj(cy_re, cy_im, a1_m);
        end
    end

    assign wr_data = '{re: px.re + py.re, im: px.im + py.im};

endmodule

/* hw/rtf_sweep_counter.sv */
module rtf_sweep_counter #(
    parameter int MIC_NUM    = 8,
    parameter int RD_LATENCY = 2
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cnt_clear,
    input  logic                         cnt_step,
    input  logic                         timer_start,
    output logic [$clog2(2*MIC_NUM)-1:0] idx,
    output logic                         src_sel,
    output logic                         last,
    output logic                         timer_done
);
    localparam int IDX_W = $clog2(2*MIC_NUM);
    localparam int TMR_W = $clog2(RD_LATENCY + 1);

    logic [TMR_W-1:0] timer;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx   <= '0;
            timer <= '0;
        end else begin
            if (cnt_clear)
                idx <= '0;
            else if (cnt_step)
                idx <= last ? '0 : idx + 1'b1;
            if (timer_start)
                timer <= TMR_W'(RD_LATENCY - 1);
            else if (timer != '0)
                timer <= timer - 1'b1;
        end
    end

    assign src_sel    = (idx >= IDX_W'(MIC_NUM));   // source when reading, row when writing
    assign last       = (idx == IDX_W'(2*MIC_NUM - 1));
    assign timer_done = (timer == '0);

endmodule

/* hw/rtf_top.sv */
module rtf_top #(
    parameter int MIC_NUM    = 8,
    parameter int RD_LATENCY = 2,
    parameter int LAMBDA     = 2684355
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    output logic                          done,
    output logic [$clog2(2*MIC_NUM)-1:0]  rd_addr,
    input  rtf_pkg::cplx_t                rd_data,
    output logic                          div_req,
    output logic [rtf_pkg::WIDE_W-1:0]    div_det,
    input  logic [rtf_pkg::RECIP_W-1:0]   div_recip,
    input  logic                          div_ack,
    output logic                          wr_en,
    output logic [$clog2(2*MIC_NUM)-1:0]  wr_addr,
    output rtf_pkg::wide_cplx_t           wr_data
);
    import rtf_pkg::*;

    localparam int IDX_W = $clog2(2*MIC_NUM);

    logic             acc_clear, acc_en, inv_load, inv_scale, proj_en;
    logic             cnt_clear, cnt_step, timer_start;
    logic [IDX_W-1:0] idx;
    logic             src_sel, last, timer_done;
    gram_t            gram;
    inv_t             inv;
    cplx_t            a0_m, a1_m;

    assign rd_addr = idx;
    assign wr_addr = idx;   // same sweep, reused for the write phase

    rtf_ctrl u_ctrl (
        .clk, .rst_n, .start, .div_ack, .last, .timer_done,
        .done, .div_req, .acc_clear, .acc_en, .inv_load, .inv_scale,
        .proj_en, .wr_en, .cnt_clear, .cnt_step, .timer_start
    );

    rtf_sweep_counter #(
        .MIC_NUM    (MIC_NUM),
        .RD_LATENCY (RD_LATENCY)
    ) u_counter (
        .clk, .rst_n, .cnt_clear, .cnt_step, .timer_start,
        .idx, .src_sel, .last, .timer_done
    );

    gram_accumulator #(
        .MIC_NUM (MIC_NUM)
    ) u_gram_acc (
        .clk, .rst_n, .acc_clear, .acc_en, .idx, .src_sel, .rd_data,
        .gram, .a0_m, .a1_m
    );

    gram_inverse #(
        .LAMBDA (LAMBDA)
    ) u_gram_inv (
        .clk, .rst_n, .inv_load, .inv_scale, .gram, .div_recip,
        .div_det, .inv
    );

    rtf_projector u_projector (
        .clk, .rst_n, .proj_en, .src_sel, .inv, .a0_m, .a1_m,
        .wr_data
    );

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module rtf_tb -o rtf_sim || exit 1
out=$(./obj_dir/rtf_sim 2>&1)
echo "$out"
echo "$out" | grep -qF "All tests passed!" && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* testbench/rtf_tb.sv */
module rtf_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import rtf_pkg::*;

    localparam int MIC_NUM    = 8;
    localparam int RD_LATENCY = 2;
    localparam int LAMBDA     = 1000;
    localparam int N          = 2 * MIC_NUM;
    localparam int IDX_W      = $clog2(N);
    localparam int TIMEOUT    = 1000;

    logic               clk, rst_n, start, done;
    logic [IDX_W-1:0]   rd_addr, wr_addr;
    cplx_t              rd_data;
    logic               div_req, div_ack, wr_en;
    logic [WIDE_W-1:0]  div_det;
    logic [RECIP_W-1:0] div_recip;
    wide_cplx_t         wr_data;

    cplx_t       smem [N];
    cplx_t       rd_pipe [RD_LATENCY] = '{default: '0};
    longint      exp_det;
    longint      exp_re [N];
    longint      exp_im [N];
    logic [31:0] lfsr;
    int          ack_delay;        // below zero means random
    int          wr_total = 0;
    int          wr_base;
    logic        running = 1'b0;

    rtf_top #(
        .MIC_NUM    (MIC_NUM),
        .RD_LATENCY (RD_LATENCY),
        .LAMBDA     (LAMBDA)
    ) u_rtf_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp)
            abort_run($sformatf("error: %s got %h expected %h", name, got, exp));
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // six bits keep det below 2^32 so the reciprocal is never zero
    function automatic logic signed [DATA_W-1:0] rand_comp();
        logic signed [5:0] v;
        v = 6'(take_bits(6));
        if (v == 6'sh20)
            v = -6'sd31;   // symmetric range
        return v;
    endfunction

    task automatic fill_samples(input bit zero);
        for (int k = 0; k < N; k++) begin
            smem[k].re = zero ? '0 : rand_comp();
            smem[k].im = zero ? '0 : rand_comp();
        end
    endtask

    // ==================================================
    // reference model of W = (A^H A + lambda I)^-1 A^H
    // ==================================================
    function automatic void reference_model();
        longint      g11, g22, gr, gi, r, i11, i22, pr, pi;
        longint      a0r, a0i, a1r, a1i;
        logic [63:0] q;
        g11 = LAMBDA;
        g22 = LAMBDA;
        gr  = 0;
        gi  = 0;
        for (int m = 0; m < MIC_NUM; m++) begin
            a0r = smem[m].re;
            a0i = smem[m].im;
            a1r = smem[m + MIC_NUM].re;
            a1i = smem[m + MIC_NUM].im;
            g11 += a0r * a0r + a0i * a0i;
            g22 += a1r * a1r + a1i * a1i;
            gr  += a0r * a1r + a0i * a1i;
            gi  += a0r * a1i - a0i * a1r;
        end
        exp_det = g11 * g22 - (gr * gr + gi * gi);
        q   = (64'd1 << 32) / exp_det;
        r   = $signed(q[31:0]);
        i11 = g22 * r;
        i22 = g11 * r;
        pr  = -gr * r;   // i12
        pi  = -gi * r;
        for (int m = 0; m < MIC_NUM; m++) begin
            a0r = smem[m].re;
            a0i = smem[m].im;
            a1r = smem[m + MIC_NUM].re;
            a1i = smem[m + MIC_NUM].im;
            exp_re[m]           = i11 * a0r + pr * a1r + pi * a1i;
            exp_im[m]           = -i11 * a0i + pi * a1r - pr * a1i;
            exp_re[m + MIC_NUM] = pr * a0r - pi * a0i + i22 * a1r;
            exp_im[m + MIC_NUM] = -pi * a0r - pr * a0i - i22 * a1i;
        end
    endfunction

    // sample memory with fixed read latency
    always @(posedge clk) begin
        rd_pipe[0] <= smem[rd_addr];
        for (int i = 1; i < RD_LATENCY; i++)
            rd_pipe[i] <= rd_pipe[i - 1];
    end
    assign rd_data = rd_pipe[RD_LATENCY - 1];

    task automatic serve_divide();
        int          delay;
        int          n;
        logic [63:0] q;
        delay = (ack_delay < 0) ? int'(take_bits(5)) : ack_delay;
        check_value("div_det", div_det, exp_det);
        q = (64'd1 << 32) / div_det;
        repeat (delay) @(posedge clk);
        div_ack   <= 1'b1;
        div_recip <= q[RECIP_W-1:0];
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT)
                abort_run("divider request was never released");
        end while (div_req);
        div_ack <= 1'b0;
    endtask

    initial begin
        div_ack   = 1'b0;
        div_recip = '0;
        forever begin
            @(posedge clk);
            if (div_req && !div_ack)
                serve_divide();
        end
    end

    // result memory side sampled mid cycle
    always @(negedge clk) begin
        if (wr_en) begin
            if (!running)
                abort_run("write strobe seen while no problem was running");
            check_value("wr_addr", wr_addr, wr_total - wr_base);
            check_value("wr_data.re", wr_data.re, exp_re[wr_addr]);
            check_value("wr_data.im", wr_data.im, exp_im[wr_addr]);
            wr_total = wr_total + 1;
        end
    end

    task automatic run_problem(input int delay);
        int n;
        reference_model();
        ack_delay = delay;
        wr_base   = wr_total;
        running   = 1'b1;
        @(posedge clk);
        start <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT)
                abort_run("timeout waiting for done to rise");
        end while (!done);
        check_value("write count", wr_total - wr_base, N);
        start <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT)
                abort_run("timeout waiting for done to fall");
        end while (done);
        running = 1'b0;
    endtask

    initial begin
        rst_n     = 1'b0;
        start     = 1'b0;
        lfsr      = 32'hf6d3;
        ack_delay = -1;
        wr_base   = 0;
        fill_samples(1'b0);
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (10) @(posedge clk);   // idle so no writes expected
        check_value("done", done, 1'b0);
        check_value("div_req", div_req, 1'b0);
        check_value("wr_en", wr_en, 1'b0);
        run_problem(-1);
        fill_samples(1'b1);             // det must come out as lambda squared
        run_problem(-1);
        fill_samples(1'b0);
        run_problem(0);
        run_problem(20);
        for (int p = 0; p < 3; p++) begin
            fill_samples(1'b0);
            run_problem(-1);
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

/* testbench/rtf_tb_properties.sv */
module rtf_tb_properties (
    input logic clk,
    input logic rst_n,
    input logic start,
    input logic done,
    input logic div_req,
    input logic div_ack,
    input logic wr_en
);
    timeunit 1ns;
    timeprecision 100ps;

    // ==================================================
    // divider four-phase handshake
    // ==================================================
    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        div_req && !div_ack |=> div_req)
        else $error("div_req dropped before div_ack");

    req_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        div_ack && !div_req |=> !div_req)
        else $error("div_req raised while div_ack still high");

    no_wr_in_done: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr_en && done))
        else $error("wr_en high while done");

    done_held: assert property (@(posedge clk) disable iff (!rst_n)
        done && start |=> done)   // start/done handshake
        else $error("done fell before start");

endmodule

bind rtf_top rtf_tb_properties u_properties (
    .clk, .rst_n, .start, .done, .div_req, .div_ack, .wr_en
);
